//--- hdl/rx_pkg.sv
package rx_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // input buffer geometry
    ////////////////////////////////////////////////////////////////////////////
    localparam int rx_bw      = 10;     // 1024 words, pointers are rx_bw+1 wide
    localparam int rx_max_len = 9600;   // jumbo limit in bytes

    ////////////////////////////////////////////////////////////////////////////
    // wishbone register map
    ////////////////////////////////////////////////////////////////////////////
    localparam int wb_aw = 4;
    localparam int wb_dw = 32;

    // word addresses
    localparam logic [wb_aw-1:0] csr_ctrl     = 4'd0;   // bit 0 rx enable
    localparam logic [wb_aw-1:0] csr_fwd_cnt  = 4'd1;   // write clears
    localparam logic [wb_aw-1:0] csr_drop_cnt = 4'd2;   // write clears
    localparam logic [wb_aw-1:0] csr_fill     = 4'd3;   // read only, words in use

    // one ibuf word
    // a frame is a descriptor word followed by its payload words
    typedef union packed {
        logic [63:0] raw;           // payload beat as received
        struct packed {
            logic [15:0] rsvd_hi;
            logic [15:0] len;       // frame length in bytes, bits 47:32
            logic [31:0] rsvd_lo;
        } desc;
    } rx_word_u;

endpackage

//--- hdl/rx_ibuf.sv
`timescale 1ns/100ps

// circular frame buffer
// write port owned by the frame writer, read port by ibuf2axis
module rx_ibuf #(
    parameter int BW = rx_pkg::rx_bw
) (
    input  logic             m_axis_aclk,
    input  logic             wr_en,
    input  logic [BW-1:0]    wr_addr,
    input  rx_pkg::rx_word_u wr_data,
    input  logic [BW-1:0]    rd_addr,
    output rx_pkg::rx_word_u rd_data       // valid one cycle after rd_addr
);

    rx_pkg::rx_word_u mem [2**BW];

    always_ff @(posedge m_axis_aclk) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
        rd_data <= mem[rd_addr];   // reader never touches uncommitted words
    end

endmodule

//--- hdl/rx_frame_writer.sv
`timescale 1ns/100ps

module rx_frame_writer #(
    parameter int BW = rx_pkg::rx_bw
) (
    input  logic             m_axis_aclk,
    input  logic             m_axis_aresetp,
    // mac beats, cannot be stalled
    input  logic [63:0]      mac_data,
    input  logic [7:0]       mac_strb,
    input  logic             mac_valid,
    input  logic             mac_last,
    input  logic             mac_bad,
    input  logic             rx_enable,        // looked at on first beat only
    input  logic [BW:0]      committed_cons,
    output logic [BW:0]      committed_prod,   // also the descriptor slot of the open frame
    output logic             wr_en,
    output logic [BW-1:0]    wr_addr,
    output rx_pkg::rx_word_u wr_data,
    output logic             frame_dropped
);

    logic             in_frame;     // first beat seen, last not yet
    logic             dropping;     // frame already dropped, skip the rest
    logic             desc_pend;    // descriptor write this cycle
    logic [BW:0]      words;        // payload words stored
    logic [15:0]      byte_len;

    logic             sof;
    logic             skip;
    logic [BW:0]      cur_words;
    logic [15:0]      cur_len;
    logic [15:0]      new_len;
    logic [BW:0]      free;
    logic [BW:0]      beat_addr;
    logic             no_room;
    logic             too_long;
    logic             drop_now;
    logic             keep;
    rx_pkg::rx_word_u desc_word;

    ////////////////////////////////////////////////////////////////////////////
    // per beat decisions
    ////////////////////////////////////////////////////////////////////////////
    assign sof       = mac_valid && !in_frame;
    assign skip      = dropping && !sof;
    assign cur_words = sof ? '0 : words;
    assign cur_len   = sof ? '0 : byte_len;
    assign new_len   = cur_len + 16'($countones(mac_strb));   // last strb contiguous

    // depth minus committed occupancy
    assign free      = {1'b1, {BW{1'b0}}} - (committed_prod - committed_cons);
    // descriptor + words so far + this beat must fit
    assign no_room   = (cur_words + (BW+1)'(2)) > free;
    assign too_long  = new_len > 16'(rx_pkg::rx_max_len);

    assign drop_now  = mac_valid && !skip &&
                       ((sof && !rx_enable) || mac_bad || no_room || too_long);
    assign keep      = mac_valid && !skip && !drop_now;

    assign frame_dropped = drop_now;   // one pulse per frame

    always_comb begin
        desc_word          = '0;
        desc_word.desc.len = byte_len;
    end

    ////////////////////////////////////////////////////////////////////////////
    // buffer write port, descriptor has priority
    ////////////////////////////////////////////////////////////////////////////
    assign beat_addr = committed_prod + cur_words + 1'b1;   // payload after descriptor slot
    assign wr_en     = keep || desc_pend;
    assign wr_addr   = desc_pend ? committed_prod[BW-1:0] : beat_addr[BW-1:0];
    assign wr_data   = desc_pend ? desc_word : rx_pkg::rx_word_u'(mac_data);

    always_ff @(posedge m_axis_aclk or negedge m_axis_aresetp) begin
        if (!m_axis_aresetp) begin
            in_frame       <= 1'b0;
            dropping       <= 1'b0;
            desc_pend      <= 1'b0;
            words          <= '0;
            byte_len       <= '0;
            committed_prod <= '0;
        end else begin
            desc_pend <= 1'b0;
            if (mac_valid) begin
                in_frame <= !mac_last;
                dropping <= (drop_now || skip) && !mac_last;
            end
            if (keep) begin
                words     <= cur_words + 1'b1;
                byte_len  <= new_len;
                desc_pend <= mac_last;   // whole frame stored
            end
            // commit, visible to the reader one cycle after the descriptor write
            if (desc_pend)
                committed_prod <= committed_prod + words + 1'b1;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////
    a_strb_full: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetp)
        mac_valid && !mac_last |-> mac_strb == 8'hff);

    a_strb_last: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetp)
        mac_valid && mac_last |-> mac_strb != 8'h00 && (mac_strb & 8'(mac_strb + 8'd1)) == 8'h00);

    // the descriptor write needs the cycle after a last beat
    a_ifg: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetp)
        mac_valid && mac_last |=> !mac_valid);

    a_no_overrun: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetp)
        (committed_prod - committed_cons) <= {1'b1, {BW{1'b0}}});

endmodule

//--- hdl/ibuf2axis.sv
`timescale 1ns/100ps

module ibuf2axis #(
    parameter int BW = rx_pkg::rx_bw
) (
    input  logic             m_axis_aclk,
    input  logic             m_axis_aresetp,
    input  logic [BW:0]      committed_prod,
    output logic [BW:0]      committed_cons,
    // ibuf read port
    output logic [BW-1:0]    rd_addr,
    input  rx_pkg::rx_word_u rd_data,
    // axis out
    output logic [63:0]      m_axis_tdata,
    output logic [7:0]       m_axis_tstrb,
    output logic [127:0]     m_axis_tuser,     // length in 15:0
    output logic             m_axis_tvalid,
    output logic             m_axis_tlast,
    input  logic             m_axis_tready,
    output logic             frame_sent
);

    // fetch side
    logic [BW:0]  rd_ptr;        // next word to read
    logic [BW:0]  rd_left;       // payload reads still to issue
    logic         hdr_wait;      // descriptor on rd_data
    logic         pay_vld;       // payload word on rd_data
    logic         pay_last;
    logic [15:0]  len;
    logic [16:0]  len_rnd;
    logic         issue_hdr;
    logic         issue_pay;

    // two word prefetch
    logic [63:0]  fq_data [2];
    logic [15:0]  fq_len  [2];
    logic [1:0]   fq_last;
    logic         fq_wp;
    logic         fq_rp;
    logic [1:0]   fq_cnt;
    logic         push;
    logic         pop;

    logic         acc_last;
    logic [16:0]  out_rnd;

    // last beat strobes from len mod 8, zero means a full word
    function automatic logic [7:0] last_strb(input logic [15:0] n);
        logic [7:0] s;
        s = (8'h01 << n[2:0]) - 8'h01;
        return (n[2:0] == 3'd0) ? 8'hff : s;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // read scheduling
    ////////////////////////////////////////////////////////////////////////////
    assign rd_addr   = rd_ptr[BW-1:0];
    assign len_rnd   = {1'b0, rd_data.desc.len} + 17'd7;
    assign issue_hdr = !hdr_wait && (rd_left == '0) && (rd_ptr != committed_prod);
    // words held + in flight stay within two
    assign issue_pay = (rd_left != '0) &&
                       (((fq_cnt + {1'b0, pay_vld}) < 2'd2) || pop);

    always_ff @(posedge m_axis_aclk or negedge m_axis_aresetp) begin
        if (!m_axis_aresetp) begin
            rd_ptr   <= '0;
            rd_left  <= '0;
            hdr_wait <= 1'b0;
            pay_vld  <= 1'b0;
        end else begin
            hdr_wait <= issue_hdr;
            pay_vld  <= issue_pay;
            if (issue_hdr || issue_pay)
                rd_ptr <= rd_ptr + 1'b1;
            if (hdr_wait)
                rd_left <= (BW+1)'(len_rnd[16:3]);   // ceil(len/8)
            else if (issue_pay)
                rd_left <= rd_left - 1'b1;
        end
    end

    always_ff @(posedge m_axis_aclk) begin
        pay_last <= issue_pay && (rd_left == (BW+1)'(1));
        if (hdr_wait)
            len <= rd_data.desc.len;
    end

    ////////////////////////////////////////////////////////////////////////////
    // prefetch fifo
    ////////////////////////////////////////////////////////////////////////////
    assign push = pay_vld;
    assign pop  = (fq_cnt != 2'd0) && (!m_axis_tvalid || m_axis_tready);

    always_ff @(posedge m_axis_aclk or negedge m_axis_aresetp) begin
        if (!m_axis_aresetp) begin
            fq_wp  <= 1'b0;
            fq_rp  <= 1'b0;
            fq_cnt <= 2'd0;
        end else begin
            if (push)
                fq_wp <= !fq_wp;
            if (pop)
                fq_rp <= !fq_rp;
            fq_cnt <= fq_cnt + {1'b0, push} - {1'b0, pop};
        end
    end

    always_ff @(posedge m_axis_aclk) begin
        if (push) begin
            fq_data[fq_wp] <= rd_data.raw;
            fq_len[fq_wp]  <= len;
            fq_last[fq_wp] <= pay_last;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output register
    ////////////////////////////////////////////////////////////////////////////
    assign acc_last   = m_axis_tvalid && m_axis_tready && m_axis_tlast;
    assign frame_sent = acc_last;
    assign out_rnd    = {1'b0, m_axis_tuser[15:0]} + 17'd7;

    always_ff @(posedge m_axis_aclk or negedge m_axis_aresetp) begin
        if (!m_axis_aresetp) begin
            m_axis_tvalid  <= 1'b0;
            committed_cons <= '0;
        end else begin
            if (pop)
                m_axis_tvalid <= 1'b1;
            else if (m_axis_tready)
                m_axis_tvalid <= 1'b0;
            // release descriptor + payload back to the writer
            if (acc_last)
                committed_cons <= committed_cons + (BW+1)'(out_rnd[16:3]) + 1'b1;
        end
    end

    always_ff @(posedge m_axis_aclk) begin
        if (pop) begin
            m_axis_tdata <= fq_data[fq_rp];
            m_axis_tlast <= fq_last[fq_rp];
            m_axis_tstrb <= fq_last[fq_rp] ? last_strb(fq_len[fq_rp]) : 8'hff;
            m_axis_tuser <= {112'd0, fq_len[fq_rp]};
        end
    end

    a_axis_hold: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetp)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tstrb) &&
            $stable(m_axis_tuser) && $stable(m_axis_tlast));

endmodule

//--- hdl/rx_csr.sv
`timescale 1ns/100ps

module rx_csr #(
    parameter int BW = rx_pkg::rx_bw
) (
    input  logic                     m_axis_aclk,
    input  logic                     m_axis_aresetp,
    // wishbone classic slave
    input  logic [rx_pkg::wb_aw-1:0] wb_adr,
    input  logic [rx_pkg::wb_dw-1:0] wb_dat_i,
    output logic [rx_pkg::wb_dw-1:0] wb_dat_o,
    input  logic                     wb_we,
    input  logic                     wb_stb,
    input  logic                     wb_cyc,
    output logic                     wb_ack,
    // datapath events and pointers
    input  logic                     frame_sent,
    input  logic                     frame_dropped,
    input  logic [BW:0]              committed_prod,
    input  logic [BW:0]              committed_cons,
    output logic                     rx_enable
);

    logic                     req;
    logic                     wr_req;
    logic [rx_pkg::wb_dw-1:0] fwd_cnt;
    logic [rx_pkg::wb_dw-1:0] drop_cnt;
    logic [BW:0]              fill;

    assign req    = wb_cyc && wb_stb && !wb_ack;   // ack drops the request for a cycle
    assign wr_req = req && wb_we;
    assign fill   = committed_prod - committed_cons;

    ////////////////////////////////////////////////////////////////////////////
    // control and counters
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge m_axis_aclk or negedge m_axis_aresetp) begin
        if (!m_axis_aresetp) begin
            wb_ack    <= 1'b0;
            rx_enable <= 1'b0;
            fwd_cnt   <= '0;
            drop_cnt  <= '0;
        end else begin
            wb_ack <= req;
            if (wr_req && wb_adr == rx_pkg::csr_ctrl)
                rx_enable <= wb_dat_i[0];
            // clear wins over a same cycle event
            if (wr_req && wb_adr == rx_pkg::csr_fwd_cnt)
                fwd_cnt <= '0;
            else if (frame_sent && fwd_cnt != '1)
                fwd_cnt <= fwd_cnt + 1'b1;     // saturates
            if (wr_req && wb_adr == rx_pkg::csr_drop_cnt)
                drop_cnt <= '0;
            else if (frame_dropped && drop_cnt != '1)
                drop_cnt <= drop_cnt + 1'b1;
        end
    end

    // read data, lands together with the ack
    always_ff @(posedge m_axis_aclk) begin
        if (req) begin
            case (wb_adr)
                rx_pkg::csr_ctrl:     wb_dat_o <= {{(rx_pkg::wb_dw-1){1'b0}}, rx_enable};
                rx_pkg::csr_fwd_cnt:  wb_dat_o <= fwd_cnt;
                rx_pkg::csr_drop_cnt: wb_dat_o <= drop_cnt;
                rx_pkg::csr_fill:     wb_dat_o <= {{(rx_pkg::wb_dw-BW-1){1'b0}}, fill};
                default:              wb_dat_o <= '0;
            endcase
        end
    end

    a_ack_in_cycle: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetp)
        wb_ack |-> wb_cyc && wb_stb);

endmodule

//--- hdl/rx_path_top.sv
`timescale 1ns/100ps

module rx_path_top #(
    parameter int BW = rx_pkg::rx_bw
) (
    input  logic                     m_axis_aclk,
    input  logic                     m_axis_aresetp,
    // from the mac
    input  logic [63:0]              mac_data,
    input  logic [7:0]               mac_strb,
    input  logic                     mac_valid,
    input  logic                     mac_last,
    input  logic                     mac_bad,
    // axis out
    output logic [63:0]              m_axis_tdata,
    output logic [7:0]               m_axis_tstrb,
    output logic [127:0]             m_axis_tuser,
    output logic                     m_axis_tvalid,
    output logic                     m_axis_tlast,
    input  logic                     m_axis_tready,
    // registers
    input  logic [rx_pkg::wb_aw-1:0] wb_adr,
    input  logic [rx_pkg::wb_dw-1:0] wb_dat_i,
    output logic [rx_pkg::wb_dw-1:0] wb_dat_o,
    input  logic                     wb_we,
    input  logic                     wb_stb,
    input  logic                     wb_cyc,
    output logic                     wb_ack
);

    logic [BW:0]      committed_prod;
    logic [BW:0]      committed_cons;
    logic             wr_en;
    logic [BW-1:0]    wr_addr;
    rx_pkg::rx_word_u wr_data;
    logic [BW-1:0]    rd_addr;
    rx_pkg::rx_word_u rd_data;
    logic             frame_sent;
    logic             frame_dropped;
    logic             rx_enable;

    // port names match the wires one to one
    rx_frame_writer #(.BW(BW)) i_rx_frame_writer (.*);

    rx_ibuf #(.BW(BW)) i_rx_ibuf (.*);

    ibuf2axis #(.BW(BW)) i_ibuf2axis (.*);

    rx_csr #(.BW(BW)) i_rx_csr (.*);

endmodule

//--- verif/tb_rx_path.sv
`timescale 1ns/100ps

module tb_rx_path;

    logic                     m_axis_aclk;
    logic                     m_axis_aresetp;
    logic [63:0]              mac_data;
    logic [7:0]               mac_strb;
    logic                     mac_valid;
    logic                     mac_last;
    logic                     mac_bad;
    logic [63:0]              m_axis_tdata;
    logic [7:0]               m_axis_tstrb;
    logic [127:0]             m_axis_tuser;
    logic                     m_axis_tvalid;
    logic                     m_axis_tlast;
    logic                     m_axis_tready;
    logic [rx_pkg::wb_aw-1:0] wb_adr;
    logic [rx_pkg::wb_dw-1:0] wb_dat_i;
    logic [rx_pkg::wb_dw-1:0] wb_dat_o;
    logic                     wb_we;
    logic                     wb_stb;
    logic                     wb_cyc;
    logic                     wb_ack;

    // reference queue with one entry per output beat {len, last, strb, data}
    logic [88:0] beat_q [$];
    logic        exp_vld = 1'b0;    // registered head of beat_q
    logic [63:0] exp_data;
    logic [7:0]  exp_strb;
    logic        exp_last;
    logic [15:0] exp_len;

    int  words_in  = 0;             // buffer words of frames expected to survive
    int  words_out = 0;             // ... and of frames that left
    int  frames_out = 0;
    int  drops_exp = 0;
    int  errors = 0;
    int  tests_run = 0;
    int  bp_mode = 0;               // 0 ready, 1 random, 2 held low
    bit  tb_enable = 1'b0;

    rx_path_top i_rx_path_top (.*);

    initial begin
        m_axis_aclk = 1'b0;
        forever #2 m_axis_aclk = ~m_axis_aclk;   // 4 ns
    end

    ////////////////////////////////////////////////////////////////////////////
    // expected values from the framing rules
    ////////////////////////////////////////////////////////////////////////////
    function automatic logic [7:0] last_beat_strb(input int len, input bit last);
        logic [7:0] s;
        s = 8'hff;
        if (last && (len % 8) != 0) begin
            s = '0;
            for (int i = 0; i < len % 8; i++)
                s[i] = 1'b1;                     // low bytes only
        end
        return s;
    endfunction

    // every frame word goes in once and out once and back-pressure about doubles it
    function automatic int run_budget();
        int words;
        words = (3 + 20 + 20 + 3 + 4) * (200 / 8 + 1) + 10 * (1500 / 8 + 1);
        return 4 * words + 60 * 8 + 5000;        // frame gaps, bus cycles, margin
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // output side tready pattern and reference queue pop
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        m_axis_tready = 1'b1;
        forever begin
            @(negedge m_axis_aclk);
            if (bp_mode == 1)
                m_axis_tready = 1'($urandom);
            else
                m_axis_tready = (bp_mode == 0);
        end
    end

    always @(posedge m_axis_aclk) begin
        if (m_axis_aresetp && m_axis_tvalid && m_axis_tready && beat_q.size() > 0) begin
            if (exp_last) begin
                frames_out++;
                words_out += 1 + (int'(exp_len) + 7) / 8;   // descriptor + payload
            end
            void'(beat_q.pop_front());
        end
        if (beat_q.size() > 0) begin
            exp_vld <= 1'b1;
            {exp_len, exp_last, exp_strb, exp_data} <= beat_q[0];
        end else begin
            exp_vld <= 1'b0;
        end
    end

    a_beat_expected: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetp)
        m_axis_tvalid && m_axis_tready |-> exp_vld)
        else begin
            errors++;
            $display("output beat at %0t while no surviving frame was pending", $time);
        end

    a_beat_match: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetp)
        m_axis_tvalid && m_axis_tready && exp_vld |->
            m_axis_tdata == exp_data && m_axis_tstrb == exp_strb &&
            m_axis_tlast == exp_last && m_axis_tuser == {112'd0, exp_len})
        else begin
            errors++;
            $display("FAILED %0t: beat data %h strb %h last %b len %0d, expected %h %h %b %0d",
                     $time, m_axis_tdata, m_axis_tstrb, m_axis_tlast, m_axis_tuser[15:0],
                     exp_data, exp_strb, exp_last, exp_len);
        end

    a_beat_hold: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetp)
        m_axis_tvalid && !m_axis_tready |=>
            m_axis_tvalid && $stable(m_axis_tdata) && $stable(m_axis_tstrb) &&
            $stable(m_axis_tuser) && $stable(m_axis_tlast))
        else begin
            errors++;
            $display("FAILED %0t: stalled beat changed before acceptance", $time);
        end

    // classic cycle with ack one cycle after the request and for one cycle only
    a_wb_ack_rise: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetp)
        wb_cyc && wb_stb && !wb_ack |=> wb_ack)
        else begin
            errors++;
            $display("wishbone ack did not follow the request at %0t", $time);
        end

    a_wb_ack_pulse: assert property (@(posedge m_axis_aclk) disable iff (!m_axis_aresetp)
        wb_ack |=> !wb_ack)
        else begin
            errors++;
            $display("wishbone ack lasted more than one cycle at %0t", $time);
        end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks start and end just after a falling edge
    ////////////////////////////////////////////////////////////////////////////
    task automatic wb_xfer(input logic we, input logic [3:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
        int n;
        n = 0;
        wb_adr   = adr;
        wb_dat_i = wdat;
        wb_we    = we;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        @(negedge m_axis_aclk);
        while (!wb_ack && n < 16) begin
            @(negedge m_axis_aclk);
            n++;
        end
        rdat = wb_dat_o;
        if (!wb_ack) begin
            errors++;
            $display("no wishbone ack for address %0d", adr);
        end
        @(negedge m_axis_aclk);              // strobe stays up over the edge that takes the ack
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge m_axis_aclk);
    endtask

    task automatic expect_reg(input logic [3:0] adr, input int exp, input string what);
        logic [31:0] rd;
        wb_xfer(1'b0, adr, '0, rd);
        assert (rd == 32'(exp))
            else begin
                errors++;
                $display("FAILED %0t: %s reads %0d, expected %0d", $time, what, rd, exp);
            end
    endtask

    task automatic write_reg(input logic [3:0] adr, input logic [31:0] val);
        logic [31:0] unused;
        wb_xfer(1'b1, adr, val, unused);
    endtask

    // one frame on the mac side where bad_beat < 0 means a good frame
    task automatic send_frame(input int len, input int bad_beat);
        int          nbeats;
        int          words;
        bit          keep;
        logic [63:0] data;
        logic [7:0]  strb;
        nbeats = (len + 7) / 8;
        words  = nbeats + 1;
        keep   = tb_enable && bad_beat < 0 &&
                 (words_in - words_out + words <= 2 ** rx_pkg::rx_bw);
        if (keep)
            words_in += words;
        else
            drops_exp++;
        for (int b = 0; b < nbeats; b++) begin
            data = '0;
            strb = '0;
            for (int k = 0; k < 8; k++) begin
                if (b * 8 + k < len) begin
                    data[k*8 +: 8] = 8'($urandom);
                    strb[k]        = 1'b1;
                end
            end
            if (keep)
                beat_q.push_back({16'(len), b == nbeats - 1,
                                  last_beat_strb(len, b == nbeats - 1), data});
            mac_data  = data;
            mac_strb  = strb;
            mac_valid = 1'b1;
            mac_last  = (b == nbeats - 1);
            mac_bad   = (b == bad_beat);
            @(negedge m_axis_aclk);
        end
        mac_valid = 1'b0;
        mac_last  = 1'b0;
        mac_bad   = 1'b0;
        repeat (4) @(negedge m_axis_aclk);   // commit lands before the next start
    endtask

    task automatic send_random(input int n, input int lo, input int hi);
        for (int i = 0; i < n; i++)
            send_frame($urandom_range(hi, lo), -1);
    endtask

    task automatic wait_drain();
        while (beat_q.size() != 0)
            @(negedge m_axis_aclk);
        repeat (4) @(negedge m_axis_aclk);   // cons pointer catches up
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before)
            $display("test %0d %s: ok", tests_run, name);
        else
            $display("test %0d %s: %0d errors", tests_run, name, errors - errs_before);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////
    initial begin
        int e;
        int drops_before;
        void'($urandom(32'h669a_2815));
        m_axis_aresetp = 1'b0;
        mac_data  = '0;
        mac_strb  = '0;
        mac_valid = 1'b0;
        mac_last  = 1'b0;
        mac_bad   = 1'b0;
        wb_adr    = '0;
        wb_dat_i  = '0;
        wb_we     = 1'b0;
        wb_stb    = 1'b0;
        wb_cyc    = 1'b0;
        repeat (3) @(posedge m_axis_aclk);
        @(negedge m_axis_aclk);
        m_axis_aresetp = 1'b1;

        // idle after reset with the port still disabled
        e = errors;
        assert (!m_axis_tvalid)
            else begin
                errors++;
                $display("FAILED %0t: tvalid high after reset", $time);
            end
        expect_reg(rx_pkg::csr_ctrl, 0, "ctrl");
        expect_reg(rx_pkg::csr_fwd_cnt, 0, "forwarded count");
        expect_reg(rx_pkg::csr_drop_cnt, 0, "dropped count");
        expect_reg(rx_pkg::csr_fill, 0, "fill");
        send_random(3, 1, 200);
        repeat (40) @(negedge m_axis_aclk);
        expect_reg(rx_pkg::csr_drop_cnt, drops_exp, "dropped count");
        report_test("reset_and_disabled", e);

        e = errors;
        write_reg(rx_pkg::csr_ctrl, 32'd1);
        tb_enable = 1'b1;
        send_random(20, 1, 200);
        wait_drain();
        report_test("in_order", e);

        e = errors;
        bp_mode = 1;
        send_random(20, 1, 200);
        wait_drain();
        bp_mode = 0;
        report_test("back_pressure", e);

        // stalled output and jumbo-ish frames until the buffer runs out
        e = errors;
        drops_before = drops_exp;
        bp_mode = 2;
        send_random(10, 1000, 1500);
        repeat (20) @(negedge m_axis_aclk);
        expect_reg(rx_pkg::csr_fill, words_in - words_out, "fill");
        expect_reg(rx_pkg::csr_drop_cnt, drops_exp, "dropped count");
        if (drops_exp == drops_before) begin
            errors++;
            $display("buffer never ran full, no frame was dropped");
        end
        bp_mode = 0;
        wait_drain();
        send_random(3, 1, 200);
        wait_drain();
        report_test("buffer_full", e);

        e = errors;
        bp_mode = 2;
        send_frame($urandom_range(200, 8), -1);
        send_frame(64, $urandom_range(7, 0));    // bad somewhere in 8 beats
        send_frame($urandom_range(200, 8), -1);
        send_frame(17, 2);                       // bad on the last beat
        repeat (20) @(negedge m_axis_aclk);
        expect_reg(rx_pkg::csr_fill, words_in - words_out, "fill");
        expect_reg(rx_pkg::csr_drop_cnt, drops_exp, "dropped count");
        bp_mode = 0;
        wait_drain();
        expect_reg(rx_pkg::csr_fwd_cnt, frames_out, "forwarded count");
        write_reg(rx_pkg::csr_fwd_cnt, '0);
        write_reg(rx_pkg::csr_drop_cnt, '0);
        expect_reg(rx_pkg::csr_fwd_cnt, 0, "forwarded count after clear");
        expect_reg(rx_pkg::csr_drop_cnt, 0, "dropped count after clear");
        report_test("bad_and_counters", e);

        $display("%0d tests, %0d frames out, %0d drops, %0d errors",
                 tests_run, frames_out, drops_exp, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    // hang guard
    initial begin
        int budget;
        budget = run_budget();
        repeat (budget) @(posedge m_axis_aclk);
        $display("run did not finish within %0d cycles, stopped by the watchdog", budget);
        $display("TEST FAILED");
        $finish;
    end

endmodule

//--- all.f
hdl/rx_pkg.sv
hdl/rx_ibuf.sv
hdl/rx_frame_writer.sv
hdl/ibuf2axis.sv
hdl/rx_csr.sv
hdl/rx_path_top.sv
verif/tb_rx_path.sv

//--- Makefile
TOP := tb_rx_path
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with verilator, run the testbench, check $(LOG) for the pass line"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -Mdir obj_dir -f all.f
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "^TEST PASSED$$" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
